//--- hbus_dual_port_top.f
hdl/hbus_pkg.sv
hdl/hbus_sync_fifo.sv
hdl/hbus_port_bridge.sv
hdl/hbus_arbiter.sv
hdl/hbus_dual_port_top.sv
tests/hbus_mem_model.sv
tests/hbus_checker.sv
tests/tb_hbus_dual_port.sv

//--- hdl/hbus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module hbus_arbiter #(
  parameter int HBUS_ADDR_WIDTH = 16
) (
  input  wire                              clk,
  input  wire                              hbus_rst,
  input  wire  [1:0]                       req_i,
  output logic [1:0]                       gnt_o,

  // Port 0
  input  wire                              p0_rrq_i,
  input  wire                              p0_wrq_i,
  input  wire  [HBUS_ADDR_WIDTH-1:0]       p0_adr_i,
  input  wire  [hbus_pkg::HBUS_DATA_W-1:0] p0_dat_i,
  output logic                             p0_ready_o,
  output logic                             p0_valid_o,
  output logic [hbus_pkg::HBUS_DATA_W-1:0] p0_dat_o,

  // Port 1
  input  wire                              p1_rrq_i,
  input  wire                              p1_wrq_i,
  input  wire  [HBUS_ADDR_WIDTH-1:0]       p1_adr_i,
  input  wire  [hbus_pkg::HBUS_DATA_W-1:0] p1_dat_i,
  output logic                             p1_ready_o,
  output logic                             p1_valid_o,
  output logic [hbus_pkg::HBUS_DATA_W-1:0] p1_dat_o,

  // Shared native bus
  input  wire                              hbus_ready_i,
  input  wire                              hbus_valid_i,
  input  wire                              hbus_busy_i,
  input  wire  [hbus_pkg::HBUS_DATA_W-1:0] hbus_dat_i,
  output logic                             hbus_rrq_o,
  output logic                             hbus_wrq_o,
  output logic [HBUS_ADDR_WIDTH-1:0]       hbus_adr_o,
  output logic [hbus_pkg::HBUS_DATA_W-1:0] hbus_dat_o
);

  // Index of the port that owned the bus last
  logic last_q;
  logic pick;
  logic bus_free;

  assign bus_free = (gnt_o == 2'b00);

  // On a tie the port not served last wins
  always_comb begin
    if (req_i == 2'b11) begin
      pick = ~last_q;
    end else begin
      pick = req_i[1];
    end
  end

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      gnt_o  <= 2'b00;
      last_q <= 1'b1;
    end else if (bus_free) begin
      if (~hbus_busy_i && (req_i != 2'b00)) begin
        gnt_o  <= pick ? 2'b10 : 2'b01;
        last_q <= pick;
      end
    end else if ((gnt_o & req_i) == 2'b00) begin
      // Owner has let go of its request
      gnt_o <= 2'b00;
    end
  end

  // Owner drives the shared bus, idle bus stays quiet
  always_comb begin
    hbus_rrq_o = 1'b0;
    hbus_wrq_o = 1'b0;
    hbus_adr_o = '0;
    hbus_dat_o = '0;
    case (gnt_o)
      2'b01: begin
        hbus_rrq_o = p0_rrq_i;
        hbus_wrq_o = p0_wrq_i;
        hbus_adr_o = p0_adr_i;
        hbus_dat_o = p0_dat_i;
      end
      2'b10: begin
        hbus_rrq_o = p1_rrq_i;
        hbus_wrq_o = p1_wrq_i;
        hbus_adr_o = p1_adr_i;
        hbus_dat_o = p1_dat_i;
      end
      default: ;
    endcase
  end

  // Responses reach the owner only
  assign p0_ready_o = gnt_o[0] & hbus_ready_i;
  assign p0_valid_o = gnt_o[0] & hbus_valid_i;
  assign p0_dat_o   = gnt_o[0] ? hbus_dat_i : '0;
  assign p1_ready_o = gnt_o[1] & hbus_ready_i;
  assign p1_valid_o = gnt_o[1] & hbus_valid_i;
  assign p1_dat_o   = gnt_o[1] ? hbus_dat_i : '0;

endmodule

`default_nettype wire

//--- hdl/hbus_dual_port_top.sv
`timescale 1ns/1ps
`default_nettype none

module hbus_dual_port_top #(
  parameter int FIFO_DATA_WIDTH = 32,
  parameter int HBUS_ADDR_WIDTH = 16,
  parameter int FIFO_ASIZE      = 3
) (
  input  wire                              clk,
  input  wire                              hbus_rst,

  // User port 0
  input  wire                              p0_rrq_i,
  input  wire                              p0_wrq_i,
  input  wire  [HBUS_ADDR_WIDTH-1:0]       p0_adr_i,
  input  wire  [FIFO_DATA_WIDTH-1:0]       p0_tx_dat_i,
  output logic                             p0_tx_ready_o,
  output logic                             p0_rx_valid_o,
  output logic [FIFO_DATA_WIDTH-1:0]       p0_rx_dat_o,

  // User port 1
  input  wire                              p1_rrq_i,
  input  wire                              p1_wrq_i,
  input  wire  [HBUS_ADDR_WIDTH-1:0]       p1_adr_i,
  input  wire  [FIFO_DATA_WIDTH-1:0]       p1_tx_dat_i,
  output logic                             p1_tx_ready_o,
  output logic                             p1_rx_valid_o,
  output logic [FIFO_DATA_WIDTH-1:0]       p1_rx_dat_o,

  // Native memory interface
  input  wire  [hbus_pkg::HBUS_DATA_W-1:0] hbus_dat_i,
  input  wire                              hbus_ready_i,
  input  wire                              hbus_valid_i,
  input  wire                              hbus_busy_i,
  output logic [HBUS_ADDR_WIDTH-1:0]       hbus_adr_o,
  output logic [hbus_pkg::HBUS_DATA_W-1:0] hbus_dat_o,
  output logic                             hbus_rrq_o,
  output logic                             hbus_wrq_o
);

  import hbus_pkg::*;

  logic [1:0]                 bus_req;
  logic [1:0]                 bus_gnt;

  // Bridge to arbiter, one set per port
  logic                       p0_bus_rrq;
  logic                       p0_bus_wrq;
  logic [HBUS_ADDR_WIDTH-1:0] p0_bus_adr;
  logic [HBUS_DATA_W-1:0]     p0_bus_wdat;
  logic                       p0_bus_ready;
  logic                       p0_bus_valid;
  logic [HBUS_DATA_W-1:0]     p0_bus_rdat;

  logic                       p1_bus_rrq;
  logic                       p1_bus_wrq;
  logic [HBUS_ADDR_WIDTH-1:0] p1_bus_adr;
  logic [HBUS_DATA_W-1:0]     p1_bus_wdat;
  logic                       p1_bus_ready;
  logic                       p1_bus_valid;
  logic [HBUS_DATA_W-1:0]     p1_bus_rdat;

  hbus_port_bridge #(
    .FIFO_DATA_WIDTH (FIFO_DATA_WIDTH),
    .HBUS_ADDR_WIDTH (HBUS_ADDR_WIDTH),
    .FIFO_ASIZE      (FIFO_ASIZE)
  ) port0 (
    .clk         (clk),
    .hbus_rst    (hbus_rst),
    .rrq_i       (p0_rrq_i),
    .wrq_i       (p0_wrq_i),
    .adr_i       (p0_adr_i),
    .tx_dat_i    (p0_tx_dat_i),
    .tx_ready_o  (p0_tx_ready_o),
    .rx_valid_o  (p0_rx_valid_o),
    .rx_dat_o    (p0_rx_dat_o),
    .bus_req_o   (bus_req[0]),
    .bus_gnt_i   (bus_gnt[0]),
    .bus_rrq_o   (p0_bus_rrq),
    .bus_wrq_o   (p0_bus_wrq),
    .bus_adr_o   (p0_bus_adr),
    .bus_dat_o   (p0_bus_wdat),
    .bus_ready_i (p0_bus_ready),
    .bus_valid_i (p0_bus_valid),
    .bus_dat_i   (p0_bus_rdat)
  );

  hbus_port_bridge #(
    .FIFO_DATA_WIDTH (FIFO_DATA_WIDTH),
    .HBUS_ADDR_WIDTH (HBUS_ADDR_WIDTH),
    .FIFO_ASIZE      (FIFO_ASIZE)
  ) port1 (
    .clk         (clk),
    .hbus_rst    (hbus_rst),
    .rrq_i       (p1_rrq_i),
    .wrq_i       (p1_wrq_i),
    .adr_i       (p1_adr_i),
    .tx_dat_i    (p1_tx_dat_i),
    .tx_ready_o  (p1_tx_ready_o),
    .rx_valid_o  (p1_rx_valid_o),
    .rx_dat_o    (p1_rx_dat_o),
    .bus_req_o   (bus_req[1]),
    .bus_gnt_i   (bus_gnt[1]),
    .bus_rrq_o   (p1_bus_rrq),
    .bus_wrq_o   (p1_bus_wrq),
    .bus_adr_o   (p1_bus_adr),
    .bus_dat_o   (p1_bus_wdat),
    .bus_ready_i (p1_bus_ready),
    .bus_valid_i (p1_bus_valid),
    .bus_dat_i   (p1_bus_rdat)
  );

  hbus_arbiter #(
    .HBUS_ADDR_WIDTH (HBUS_ADDR_WIDTH)
  ) arbiter (
    .clk          (clk),
    .hbus_rst     (hbus_rst),
    .req_i        (bus_req),
    .gnt_o        (bus_gnt),
    .p0_rrq_i     (p0_bus_rrq),
    .p0_wrq_i     (p0_bus_wrq),
    .p0_adr_i     (p0_bus_adr),
    .p0_dat_i     (p0_bus_wdat),
    .p0_ready_o   (p0_bus_ready),
    .p0_valid_o   (p0_bus_valid),
    .p0_dat_o     (p0_bus_rdat),
    .p1_rrq_i     (p1_bus_rrq),
    .p1_wrq_i     (p1_bus_wrq),
    .p1_adr_i     (p1_bus_adr),
    .p1_dat_i     (p1_bus_wdat),
    .p1_ready_o   (p1_bus_ready),
    .p1_valid_o   (p1_bus_valid),
    .p1_dat_o     (p1_bus_rdat),
    .hbus_ready_i (hbus_ready_i),
    .hbus_valid_i (hbus_valid_i),
    .hbus_busy_i  (hbus_busy_i),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_rrq_o   (hbus_rrq_o),
    .hbus_wrq_o   (hbus_wrq_o),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_o   (hbus_dat_o)
  );

endmodule

`default_nettype wire

//--- hdl/hbus_pkg.sv
`default_nettype none

package hbus_pkg;

  // Width of one beat on the native memory interface
  localparam int HBUS_DATA_W = 16;

  // Bus-side state of one port bridge
  typedef enum logic [1:0] {
    // No command pending
    IDLE  = 2'd0,
    // Waiting for the arbiter grant
    REQ   = 2'd1,
    // Collecting read beats
    READ  = 2'd2,
    // Sending write beats
    WRITE = 2'd3
  } bridge_state_t;

  // Request opcode stored in the command FIFO
  typedef enum logic {
    CMD_WRITE = 1'b0,
    CMD_READ  = 1'b1
  } hbus_cmd_t;

endpackage

`default_nettype wire

//--- hdl/hbus_port_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module hbus_port_bridge #(
  parameter int FIFO_DATA_WIDTH = 32,
  parameter int HBUS_ADDR_WIDTH = 16,
  parameter int FIFO_ASIZE      = 3
) (
  input  wire                             clk,
  input  wire                             hbus_rst,

  // User side
  input  wire                             rrq_i,
  input  wire                             wrq_i,
  input  wire [HBUS_ADDR_WIDTH-1:0]       adr_i,
  input  wire [FIFO_DATA_WIDTH-1:0]       tx_dat_i,
  output logic                            tx_ready_o,
  output logic                            rx_valid_o,
  output logic [FIFO_DATA_WIDTH-1:0]      rx_dat_o,

  // Arbiter side
  output logic                            bus_req_o,
  input  wire                             bus_gnt_i,
  output logic                            bus_rrq_o,
  output logic                            bus_wrq_o,
  output logic [HBUS_ADDR_WIDTH-1:0]      bus_adr_o,
  output logic [hbus_pkg::HBUS_DATA_W-1:0] bus_dat_o,
  input  wire                             bus_ready_i,
  input  wire                             bus_valid_i,
  input  wire [hbus_pkg::HBUS_DATA_W-1:0] bus_dat_i
);

  import hbus_pkg::*;

  // Bus beats per user word
  localparam int BEATS = FIFO_DATA_WIDTH / HBUS_DATA_W;
  localparam int CNT_W = $clog2(BEATS + 1);
  localparam int CMD_W = HBUS_ADDR_WIDTH + 1;

  bridge_state_t              state;
  logic [CNT_W-1:0]           beat_cnt;
  logic                       busy;
  logic                       accept;
  hbus_cmd_t                  req_op;
  hbus_cmd_t                  cmd_op;
  logic                       cmd_ready;
  logic                       start;
  logic                       wr_beat;
  logic                       rd_beat;

  logic                       cmd_winc;
  logic                       cmd_rinc;
  logic                       cmd_wfull;
  logic                       cmd_rempty;
  logic [CMD_W-1:0]           cmd_wdata;
  logic [CMD_W-1:0]           cmd_rdata;

  logic                       tx_winc;
  logic                       tx_rinc;
  logic                       tx_wfull;
  logic                       tx_rempty;
  logic [FIFO_DATA_WIDTH-1:0] tx_rdata;

  logic                       rx_winc;
  logic                       rx_rinc;
  logic                       rx_wfull;
  logic                       rx_rempty;

  logic [FIFO_DATA_WIDTH-1:0] tx_shift;
  logic [FIFO_DATA_WIDTH-1:0] rx_shift;

  // User side, read wins if both strobes arrive together
  assign req_op    = rrq_i ? CMD_READ : CMD_WRITE;
  assign accept    = ~busy & (rrq_i | wrq_i) & ~cmd_wfull & ~tx_wfull;
  assign cmd_winc  = accept;
  assign cmd_wdata = {req_op, adr_i};
  assign tx_winc   = accept & (req_op == CMD_WRITE);

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end else if (tx_ready_o | rx_valid_o) begin
      busy <= 1'b0;
    end
  end

  hbus_sync_fifo #(.DSIZE(CMD_W), .ASIZE(FIFO_ASIZE)) cmd_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .winc_i   (cmd_winc),
    .wdata_i  (cmd_wdata),
    .rinc_i   (cmd_rinc),
    .rdata_o  (cmd_rdata),
    .wfull_o  (cmd_wfull),
    .rempty_o (cmd_rempty)
  );

  hbus_sync_fifo #(.DSIZE(FIFO_DATA_WIDTH), .ASIZE(FIFO_ASIZE)) tx_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .winc_i   (tx_winc),
    .wdata_i  (tx_dat_i),
    .rinc_i   (tx_rinc),
    .rdata_o  (tx_rdata),
    .wfull_o  (tx_wfull),
    .rempty_o (tx_rempty)
  );

  hbus_sync_fifo #(.DSIZE(FIFO_DATA_WIDTH), .ASIZE(FIFO_ASIZE)) rx_fifo (
    .clk      (clk),
    .hbus_rst (hbus_rst),
    .winc_i   (rx_winc),
    .wdata_i  (rx_shift),
    .rinc_i   (rx_rinc),
    .rdata_o  (rx_dat_o),
    .wfull_o  (rx_wfull),
    .rempty_o (rx_rempty)
  );

  // A write needs its data word queued as well
  assign cmd_op    = hbus_cmd_t'(cmd_rdata[CMD_W-1]);
  assign cmd_ready = ~cmd_rempty & ((cmd_op == CMD_READ) | ~tx_rempty);

  assign start    = (state == REQ) & bus_gnt_i;
  assign cmd_rinc = start;
  assign tx_rinc  = start & (cmd_op == CMD_WRITE);
  assign wr_beat  = (state == WRITE) & (beat_cnt != '0) & bus_ready_i;
  assign rd_beat  = (state == READ) & (beat_cnt != '0) & bus_valid_i;

  // Assembled word goes to the RX FIFO in the closing cycle
  assign rx_winc    = (state == READ) & (beat_cnt == '0) & ~rx_wfull;
  assign rx_rinc    = ~rx_rempty;
  assign rx_valid_o = ~rx_rempty;

  // Most significant beat leaves first
  assign bus_dat_o = tx_shift[FIFO_DATA_WIDTH-1 -: HBUS_DATA_W];

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      state      <= IDLE;
      beat_cnt   <= '0;
      bus_req_o  <= 1'b0;
      bus_rrq_o  <= 1'b0;
      bus_wrq_o  <= 1'b0;
      tx_ready_o <= 1'b0;
    end else begin
      tx_ready_o <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd_ready) begin
            bus_req_o <= 1'b1;
            state     <= REQ;
          end
        end
        REQ: begin
          if (bus_gnt_i) begin
            beat_cnt <= CNT_W'(BEATS);
            if (cmd_op == CMD_WRITE) begin
              bus_wrq_o <= 1'b1;
              state     <= WRITE;
            end else begin
              bus_rrq_o <= 1'b1;
              state     <= READ;
            end
          end
        end
        READ: begin
          if (beat_cnt == '0) begin
            bus_req_o <= 1'b0;
            state     <= IDLE;
          end else if (rd_beat) begin
            beat_cnt <= beat_cnt - 1'b1;
            if (beat_cnt == CNT_W'(1)) begin
              bus_rrq_o <= 1'b0;
            end
          end
        end
        WRITE: begin
          if (beat_cnt == '0) begin
            bus_req_o  <= 1'b0;
            tx_ready_o <= 1'b1;
            state      <= IDLE;
          end else if (wr_beat) begin
            beat_cnt <= beat_cnt - 1'b1;
            if (beat_cnt == CNT_W'(1)) begin
              bus_wrq_o <= 1'b0;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address and data shift registers
  always_ff @(posedge clk) begin
    if (start) begin
      bus_adr_o <= cmd_rdata[HBUS_ADDR_WIDTH-1:0];
      tx_shift  <= tx_rdata;
      rx_shift  <= '0;
    end else if (wr_beat) begin
      tx_shift <= tx_shift << HBUS_DATA_W;
    end else if (rd_beat) begin
      rx_shift <= (rx_shift << HBUS_DATA_W) | FIFO_DATA_WIDTH'(bus_dat_i);
    end
  end

endmodule

`default_nettype wire

//--- hdl/hbus_sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module hbus_sync_fifo #(
  parameter int DSIZE = 32,
  parameter int ASIZE = 3
) (
  input  wire              clk,
  input  wire              hbus_rst,
  input  wire              winc_i,
  input  wire [DSIZE-1:0]  wdata_i,
  input  wire              rinc_i,
  output logic [DSIZE-1:0] rdata_o,
  output logic             wfull_o,
  output logic             rempty_o
);

  localparam int DEPTH = 2 ** ASIZE;

  logic [DSIZE-1:0] mem [DEPTH];

  // Pointers carry one extra wrap bit to tell full from empty
  logic [ASIZE:0] wptr;
  logic [ASIZE:0] rptr;
  logic           do_write;
  logic           do_read;

  assign wfull_o  = (wptr[ASIZE] != rptr[ASIZE]) &&
                    (wptr[ASIZE-1:0] == rptr[ASIZE-1:0]);
  assign rempty_o = (wptr == rptr);

  assign do_write = winc_i & ~wfull_o;
  assign do_read  = rinc_i & ~rempty_o;

  // Show-ahead data, the head entry is visible before the pop
  assign rdata_o = mem[rptr[ASIZE-1:0]];

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      wptr <= '0;
    end else if (do_write) begin
      wptr <= wptr + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      rptr <= '0;
    end else if (do_read) begin
      rptr <= rptr + 1'b1;
    end
  end

  // Storage array
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wptr[ASIZE-1:0]] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dual-port bridge regression with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal \
  -f hbus_dual_port_top.f \
  --top-module tb_hbus_dual_port \
  -o tb_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; cat build.log; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "Regression failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Regression passed" sim.log || { echo "No pass line found in sim.log"; exit 1; }
exit 0

//--- tests/hbus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module hbus_checker #(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 32
) (
  input  wire              clk,
  input  wire              hbus_rst,
  input  wire              p0_rrq_i,
  input  wire              p0_wrq_i,
  input  wire [ADDR_W-1:0] p0_adr_i,
  input  wire [DATA_W-1:0] p0_tx_dat_i,
  input  wire              p0_tx_ready_i,
  input  wire              p0_rx_valid_i,
  input  wire [DATA_W-1:0] p0_rx_dat_i,
  input  wire              p1_rrq_i,
  input  wire              p1_wrq_i,
  input  wire [ADDR_W-1:0] p1_adr_i,
  input  wire [DATA_W-1:0] p1_tx_dat_i,
  input  wire              p1_tx_ready_i,
  input  wire              p1_rx_valid_i,
  input  wire [DATA_W-1:0] p1_rx_dat_i,
  input  wire              hbus_rrq_i,
  input  wire              hbus_wrq_i,
  input  wire              hbus_busy_i,
  input  wire              hbus_ready_i,
  input  wire [ADDR_W-1:0] hbus_adr_i,
  input  wire [15:0]       hbus_dat_i,
  output int               error_count,
  output int               check_count
);

  // Reference word memory, filled by finished writes
  logic [DATA_W-1:0] ref_mem [int];
  logic              pending   [2];
  logic              pend_read [2];
  logic [ADDR_W-1:0] pend_adr  [2];
  logic [DATA_W-1:0] pend_dat  [2];
  logic              rrq_q;
  logic              wrq_q;
  logic              busy_d1;
  logic              busy_d2;
  logic              in_reset_q;
  // Low for the high half of a write word, high for the low half
  logic              beat_q;
  int                owner;
  logic [15:0]       exp_beat;

  initial begin
    error_count = 0;
    check_count = 0;
    in_reset_q  = 1'b0;
    for (int p = 0; p < 2; p++) begin
      pending[p] = 1'b0;
    end
  end

  // Unwritten words read back the cell fill pattern
  function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] adr);
    logic [15:0] hi;
    logic [15:0] lo;
    if (ref_mem.exists(int'(adr))) begin
      return ref_mem[int'(adr)];
    end
    hi = {adr[14:0], 1'b0} ^ 16'h5a5a;
    lo = {adr[14:0], 1'b1} ^ 16'h5a5a;
    return {hi, lo};
  endfunction

  // Port whose outstanding request matches the bus direction and address
  function automatic int bus_owner(input logic rd, input logic [ADDR_W-1:0] adr);
    for (int p = 0; p < 2; p++) begin
      if (pending[p] && (pend_read[p] == rd) && (pend_adr[p] == adr)) begin
        return p;
      end
    end
    return -1;
  endfunction

  task automatic expect_low(input logic val, input string name);
    check_count++;
    if (val !== 1'b0) begin
      error_count++;
      $display("FAIL %0t %s expected 0 actual %b", $time, name, val);
    end
  endtask

  task automatic port_step(input int p, input logic rrq, input logic wrq,
                           input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                           input logic tx_ready, input logic rx_valid,
                           input logic [DATA_W-1:0] rx_dat);
    logic              was_pending;
    logic [DATA_W-1:0] exp;
    was_pending = pending[p];
    if (tx_ready) begin
      check_count++;
      if (!pending[p] || pend_read[p]) begin
        error_count++;
        $display("ERROR at %0t: port %0d finished a write it was never given", $time, p);
      end else begin
        ref_mem[int'(pend_adr[p])] = pend_dat[p];
      end
      pending[p] = 1'b0;
    end
    if (rx_valid) begin
      check_count++;
      if (!pending[p] || !pend_read[p]) begin
        error_count++;
        $display("ERROR at %0t: port %0d returned read data with no read outstanding",
                 $time, p);
      end else begin
        exp = expected_word(pend_adr[p]);
        if (rx_dat !== exp) begin
          error_count++;
          $display("FAIL %0t p%0d_rx_dat_o expected %h actual %h", $time, p, exp, rx_dat);
        end
      end
      pending[p] = 1'b0;
    end
    // A busy port drops the strobe, read wins over write
    if (!was_pending && (rrq || wrq)) begin
      pending[p]   = 1'b1;
      pend_read[p] = rrq;
      pend_adr[p]  = adr;
      pend_dat[p]  = dat;
    end
  endtask

  always @(posedge clk) begin
    // Reset values have settled by the second reset edge
    if (in_reset_q) begin
      expect_low(p0_tx_ready_i, "p0_tx_ready_o");
      expect_low(p0_rx_valid_i, "p0_rx_valid_o");
      expect_low(p1_tx_ready_i, "p1_tx_ready_o");
      expect_low(p1_rx_valid_i, "p1_rx_valid_o");
      expect_low(hbus_rrq_i, "hbus_rrq_o");
      expect_low(hbus_wrq_i, "hbus_wrq_o");
    end
    if (hbus_rst) begin
      pending[0] = 1'b0;
      pending[1] = 1'b0;
    end else begin
      port_step(0, p0_rrq_i, p0_wrq_i, p0_adr_i, p0_tx_dat_i,
                p0_tx_ready_i, p0_rx_valid_i, p0_rx_dat_i);
      port_step(1, p1_rrq_i, p1_wrq_i, p1_adr_i, p1_tx_dat_i,
                p1_tx_ready_i, p1_rx_valid_i, p1_rx_dat_i);
      if (hbus_rrq_i && hbus_wrq_i) begin
        error_count++;
        $display("ERROR at %0t: hbus_rrq_o and hbus_wrq_o are high together", $time);
      end
      // A grant taken two samples back decides the rise of the request
      if (((hbus_rrq_i && !rrq_q) || (hbus_wrq_i && !wrq_q)) && busy_d2) begin
        error_count++;
        $display("ERROR at %0t: a bus request started while hbus_busy_i was high", $time);
      end
      // Bus address and write beats follow the outstanding request
      if (hbus_rrq_i || hbus_wrq_i) begin
        owner = bus_owner(hbus_rrq_i, hbus_adr_i);
        check_count++;
        if (owner < 0) begin
          error_count++;
          $display("ERROR at %0t: hbus_adr_o %h matches no outstanding request",
                   $time, hbus_adr_i);
        end else if (hbus_wrq_i && hbus_ready_i) begin
          exp_beat = beat_q ? pend_dat[owner][15:0] : pend_dat[owner][DATA_W-1 -: 16];
          check_count++;
          if (hbus_dat_i !== exp_beat) begin
            error_count++;
            $display("FAIL %0t hbus_dat_o expected %h actual %h", $time, exp_beat, hbus_dat_i);
          end
        end
      end
    end
    if (!hbus_wrq_i) begin
      beat_q <= 1'b0;
    end else if (hbus_ready_i) begin
      beat_q <= ~beat_q;
    end
    in_reset_q <= hbus_rst;
    rrq_q      <= hbus_rrq_i;
    wrq_q      <= hbus_wrq_i;
    busy_d1    <= hbus_busy_i;
    busy_d2    <= busy_d1;
  end

endmodule

`default_nettype wire

//--- tests/hbus_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module hbus_mem_model #(
  parameter int ADDR_W     = 16,
  parameter int BUSY_START = 60,
  parameter int BUSY_LEN   = 30
) (
  input  wire               clk,
  input  wire               hbus_rst,
  input  wire               rrq_i,
  input  wire               wrq_i,
  input  wire  [ADDR_W-1:0] adr_i,
  input  wire  [15:0]       dat_i,
  output logic [15:0]       dat_o,
  output logic              ready_o,
  output logic              valid_o,
  output logic              busy_o
);

  // Beat cells, word A lives in cells 2A and 2A+1
  logic [15:0] cells [0:1023];
  logic        stall;
  logic        beat;
  logic [9:0]  cell_idx;
  int          cycle;

  initial begin
    for (int n = 0; n < 1024; n++) begin
      cells[n] = 16'(n) ^ 16'h5a5a;
    end
  end

  assign cell_idx = {adr_i[8:0], beat};
  assign ready_o  = wrq_i & ~stall;
  assign valid_o  = rrq_i & ~stall;
  assign dat_o    = cells[cell_idx];

  always_ff @(posedge clk or posedge hbus_rst) begin
    if (hbus_rst) begin
      stall  <= 1'b0;
      beat   <= 1'b0;
      cycle  <= 0;
      busy_o <= 1'b0;
    end else begin
      cycle  <= cycle + 1;
      // Roughly one cycle in four stalls the beat
      stall  <= ($urandom % 4) == 0;
      busy_o <= (cycle >= BUSY_START) && (cycle < BUSY_START + BUSY_LEN);
      if ((rrq_i & valid_o) | (wrq_i & ready_o)) begin
        beat <= ~beat;
      end else if (~rrq_i & ~wrq_i) begin
        beat <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    if (wrq_i & ready_o) begin
      cells[cell_idx] <= dat_i;
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_hbus_dual_port.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hbus_dual_port;

  localparam int ADDR_W  = 16;
  localparam int DATA_W  = 32;
  localparam int N       = 20;
  localparam int TIMEOUT = 300;

  logic              clk;
  logic              hbus_rst;
  logic              p0_rrq;
  logic              p0_wrq;
  logic [ADDR_W-1:0] p0_adr;
  logic [DATA_W-1:0] p0_tx_dat;
  logic              p0_tx_ready;
  logic              p0_rx_valid;
  logic [DATA_W-1:0] p0_rx_dat;
  logic              p1_rrq;
  logic              p1_wrq;
  logic [ADDR_W-1:0] p1_adr;
  logic [DATA_W-1:0] p1_tx_dat;
  logic              p1_tx_ready;
  logic              p1_rx_valid;
  logic [DATA_W-1:0] p1_rx_dat;
  logic [15:0]       hbus_dat_in;
  logic [15:0]       hbus_dat_out;
  logic [ADDR_W-1:0] hbus_adr;
  logic              hbus_ready;
  logic              hbus_valid;
  logic              hbus_busy;
  logic              hbus_rrq;
  logic              hbus_wrq;
  int                error_count;
  int                check_count;
  logic              timed_out;

  // Stimulus table: port, read, address, write data, issue with next, extra strobe while busy
  int                t_port  [N];
  logic              t_read  [N];
  logic [ADDR_W-1:0] t_adr   [N];
  logic [DATA_W-1:0] t_dat   [N];
  logic              t_with  [N];
  logic              t_poke  [N];

  hbus_dual_port_top #(
    .FIFO_DATA_WIDTH (DATA_W),
    .HBUS_ADDR_WIDTH (ADDR_W),
    .FIFO_ASIZE      (3)
  ) uut (
    .clk (clk), .hbus_rst (hbus_rst),
    .p0_rrq_i (p0_rrq), .p0_wrq_i (p0_wrq), .p0_adr_i (p0_adr), .p0_tx_dat_i (p0_tx_dat),
    .p0_tx_ready_o (p0_tx_ready), .p0_rx_valid_o (p0_rx_valid), .p0_rx_dat_o (p0_rx_dat),
    .p1_rrq_i (p1_rrq), .p1_wrq_i (p1_wrq), .p1_adr_i (p1_adr), .p1_tx_dat_i (p1_tx_dat),
    .p1_tx_ready_o (p1_tx_ready), .p1_rx_valid_o (p1_rx_valid), .p1_rx_dat_o (p1_rx_dat),
    .hbus_dat_i (hbus_dat_in), .hbus_ready_i (hbus_ready), .hbus_valid_i (hbus_valid),
    .hbus_busy_i (hbus_busy), .hbus_adr_o (hbus_adr), .hbus_dat_o (hbus_dat_out),
    .hbus_rrq_o (hbus_rrq), .hbus_wrq_o (hbus_wrq)
  );

  hbus_mem_model #(.ADDR_W(ADDR_W)) mem (
    .clk (clk), .hbus_rst (hbus_rst), .rrq_i (hbus_rrq), .wrq_i (hbus_wrq),
    .adr_i (hbus_adr), .dat_i (hbus_dat_out), .dat_o (hbus_dat_in),
    .ready_o (hbus_ready), .valid_o (hbus_valid), .busy_o (hbus_busy)
  );

  hbus_checker #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) chk (
    .clk (clk), .hbus_rst (hbus_rst),
    .p0_rrq_i (p0_rrq), .p0_wrq_i (p0_wrq), .p0_adr_i (p0_adr), .p0_tx_dat_i (p0_tx_dat),
    .p0_tx_ready_i (p0_tx_ready), .p0_rx_valid_i (p0_rx_valid), .p0_rx_dat_i (p0_rx_dat),
    .p1_rrq_i (p1_rrq), .p1_wrq_i (p1_wrq), .p1_adr_i (p1_adr), .p1_tx_dat_i (p1_tx_dat),
    .p1_tx_ready_i (p1_tx_ready), .p1_rx_valid_i (p1_rx_valid), .p1_rx_dat_i (p1_rx_dat),
    .hbus_rrq_i (hbus_rrq), .hbus_wrq_i (hbus_wrq), .hbus_busy_i (hbus_busy),
    .hbus_ready_i (hbus_ready), .hbus_adr_i (hbus_adr), .hbus_dat_i (hbus_dat_out),
    .error_count (error_count), .check_count (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic add_entry(input int k, input int port, input logic rd,
                           input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                           input logic with_next, input logic poke);
    t_port[k] = port;
    t_read[k] = rd;
    t_adr[k]  = adr;
    t_dat[k]  = dat;
    t_with[k] = with_next;
    t_poke[k] = poke;
  endtask

  task automatic drive_strobe(input int port, input logic rd, input logic wr,
                              input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
    if (port == 0) begin
      p0_rrq    = rd;
      p0_wrq    = wr;
      p0_adr    = adr;
      p0_tx_dat = dat;
    end else begin
      p1_rrq    = rd;
      p1_wrq    = wr;
      p1_adr    = adr;
      p1_tx_dat = dat;
    end
  endtask

  task automatic clear_strobes();
    p0_rrq = 1'b0;
    p0_wrq = 1'b0;
    p1_rrq = 1'b0;
    p1_wrq = 1'b0;
  endtask

  // Waits for the completion pulse of every issued port
  task automatic wait_done(input logic need0_in, input logic need1_in, input int k);
    int   cycles;
    logic need0;
    logic need1;
    cycles = 0;
    need0  = need0_in;
    need1  = need1_in;
    while ((need0 || need1) && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      if (p0_tx_ready || p0_rx_valid) need0 = 1'b0;
      if (p1_tx_ready || p1_rx_valid) need1 = 1'b0;
      cycles++;
    end
    if (need0 || need1) begin
      timed_out = 1'b1;
      $display("Timeout: entry %0d got no completion pulse within %0d cycles", k, TIMEOUT);
    end
  endtask

  initial begin
    int   i;
    logic need0;
    logic need1;
    void'($urandom(32'hd141));
    timed_out = 1'b0;
    hbus_rst  = 1'b1;
    p0_adr    = '0;
    p0_tx_dat = '0;
    p1_adr    = '0;
    p1_tx_dat = '0;
    clear_strobes();

    add_entry(0,  0, 1'b0, 16'h010, 32'hdeadbeef, 1'b0, 1'b0);
    add_entry(1,  0, 1'b1, 16'h010, 32'h0,        1'b0, 1'b0);
    add_entry(2,  0, 1'b1, 16'h020, 32'h0,        1'b0, 1'b0);
    add_entry(3,  1, 1'b1, 16'h033, 32'h0,        1'b0, 1'b0);
    add_entry(4,  0, 1'b0, 16'h040, 32'h11112222, 1'b1, 1'b0);
    add_entry(5,  1, 1'b0, 16'h041, 32'h33334444, 1'b0, 1'b0);
    add_entry(6,  0, 1'b1, 16'h041, 32'h0,        1'b1, 1'b0);
    add_entry(7,  1, 1'b1, 16'h040, 32'h0,        1'b0, 1'b0);
    add_entry(8,  1, 1'b0, 16'h050, 32'ha5a55a5a, 1'b0, 1'b1);
    add_entry(9,  1, 1'b1, 16'h050, 32'h0,        1'b0, 1'b0);
    add_entry(10, 0, 1'b1, 16'h050, 32'h0,        1'b1, 1'b0);
    add_entry(11, 1, 1'b0, 16'h060, 32'hcafef00d, 1'b0, 1'b0);
    add_entry(12, 0, 1'b0, 16'h070, 32'h0bad0bad, 1'b1, 1'b0);
    add_entry(13, 1, 1'b0, 16'h071, 32'h12345678, 1'b0, 1'b0);
    add_entry(14, 0, 1'b1, 16'h071, 32'h0,        1'b1, 1'b0);
    add_entry(15, 1, 1'b1, 16'h070, 32'h0,        1'b0, 1'b0);
    add_entry(16, 1, 1'b1, 16'h060, 32'h0,        1'b0, 1'b0);
    add_entry(17, 0, 1'b1, 16'h1ff, 32'h0,        1'b0, 1'b0);
    add_entry(18, 1, 1'b0, 16'h1ff, 32'h89abcdef, 1'b0, 1'b1);
    add_entry(19, 0, 1'b1, 16'h1ff, 32'h0,        1'b0, 1'b0);

    repeat (2) @(posedge clk);
    #1;
    hbus_rst = 1'b0;
    repeat (2) @(posedge clk);
    #1;

    i = 0;
    while (i < N && !timed_out) begin
      need0 = (t_port[i] == 0);
      need1 = (t_port[i] == 1);
      drive_strobe(t_port[i], t_read[i], !t_read[i], t_adr[i], t_dat[i]);
      if (t_with[i] && i + 1 < N) begin
        i++;
        drive_strobe(t_port[i], t_read[i], !t_read[i], t_adr[i], t_dat[i]);
        if (t_port[i] == 0) need0 = 1'b1;
        else need1 = 1'b1;
      end
      @(posedge clk);
      #1;
      clear_strobes();
      // This strobe lands on a busy port and must be dropped
      if (t_poke[i]) begin
        drive_strobe(t_port[i], 1'b0, 1'b1, t_adr[i], ~t_dat[i]);
        @(posedge clk);
        #1;
        clear_strobes();
      end
      wait_done(need0, need1, i);
      @(posedge clk);
      #1;
      i++;
    end

    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d, timeout: %0d", check_count, error_count, timed_out);
    if (timed_out || error_count != 0) begin
      $display("Regression failed");
    end else begin
      $display("Regression passed");
    end
    $finish;
  end

endmodule

`default_nettype wire
